/* hw/eth_crc32.sv */
`timescale 1ns/1ps

module eth_crc32 import eth_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        init_i,
   input  logic        en_i,
   input  logic [3:0]  nibble_i,
   output logic [31:0] crc_o
);

   logic [31:0] crc_next;

   // Four serial LFSR steps, bit 0 of the nibble goes first
   always_comb begin
      crc_next = crc_o;
      for (int i = 0; i < 4; i++) begin
         if (crc_next[0] ^ nibble_i[i]) begin
            crc_next = (crc_next >> 1) ^ CRC_POLY;
         end else begin
            crc_next = crc_next >> 1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         crc_o <= CRC_INIT;
      end else if (init_i) begin
         crc_o <= CRC_INIT;   // New frame
      end else if (en_i) begin
         crc_o <= crc_next;
      end
   end

   // Callers must never restart the CRC in a cycle that also feeds it
   a_init_en_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(init_i && en_i))
      else $error("eth_crc32: init and enable together");

endmodule

/* hw/eth_frame_ram.sv */
`timescale 1ns/1ps

module eth_frame_ram import eth_pkg::*; (
   input  logic                clk_i,
   input  logic                wen_i,
   input  logic [BUFFER_W-1:0] waddr_i,
   input  logic [7:0]          wdata_i,
   input  logic [BUFFER_W-1:0] raddr_i,
   output logic [7:0]          rdata_o
);

   logic [7:0] mem [2**BUFFER_W];

   always_ff @(posedge clk_i) begin
      if (wen_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // Registered read, new data wins on an address clash
   always_ff @(posedge clk_i) begin
      if (wen_i && (waddr_i == raddr_i)) begin
         rdata_o <= wdata_i;
      end else begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

/* hw/eth_mac.sv */
`timescale 1ns/1ps

module eth_mac import eth_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   // Host bus
   input  logic                  req_i,
   input  logic                  we_i,
   input  logic [REG_ADDR_W-1:0] addr_i,
   input  logic [31:0]           wdata_i,
   output logic [31:0]           rdata_o,
   output logic                  rvalid_o,
   // MII
   output logic                  tx_en_o,
   output logic [3:0]            txd_o,
   input  logic                  rx_dv_i,
   input  logic [3:0]            rxd_i,
   output logic                  irq_o
);

   logic                tx_send;
   logic                tx_crc_en;
   logic [BUFFER_W-1:0] tx_nbytes;
   logic                tx_ready;
   logic                tx_wen;
   logic [BUFFER_W-1:0] tx_waddr;
   logic [7:0]          tx_wdata;
   logic [BUFFER_W-1:0] tx_raddr;
   logic [7:0]          tx_rdata;
   logic                rx_wen;
   logic [BUFFER_W-1:0] rx_waddr;
   logic [7:0]          rx_wdata;
   logic [BUFFER_W-1:0] rx_raddr;
   logic [7:0]          rx_rdata;
   logic                rx_en;
   logic                rx_ack;
   logic                rx_done;
   logic                rx_crc_err;
   logic [BUFFER_W-1:0] rx_nbytes;

   eth_regs u_regs (
      .clk_i      (clk_i),      .rst_n_i    (rst_n_i),
      .req_i      (req_i),      .we_i       (we_i),
      .addr_i     (addr_i),     .wdata_i    (wdata_i),
      .rdata_o    (rdata_o),    .rvalid_o   (rvalid_o),
      .send_o     (tx_send),    .crc_en_o   (tx_crc_en),
      .nbytes_o   (tx_nbytes),  .tx_ready_i (tx_ready),
      .tx_wen_o   (tx_wen),     .tx_waddr_o (tx_waddr),
      .tx_wdata_o (tx_wdata),   .rx_raddr_o (rx_raddr),
      .rx_rdata_i (rx_rdata),   .rx_en_o    (rx_en),
      .rx_ack_o   (rx_ack),     .rx_done_i  (rx_done),
      .crc_err_i  (rx_crc_err), .rx_nbytes_i(rx_nbytes),
      .irq_o      (irq_o)
   );

   // Host writes, transmitter reads
   eth_frame_ram u_tx_buf (
      .clk_i  (clk_i),
      .wen_i  (tx_wen),
      .waddr_i(tx_waddr),
      .wdata_i(tx_wdata),
      .raddr_i(tx_raddr),
      .rdata_o(tx_rdata)
   );

   eth_tx u_tx (
      .clk_i    (clk_i),     .rst_n_i  (rst_n_i),
      .send_i   (tx_send),   .crc_en_i (tx_crc_en),
      .nbytes_i (tx_nbytes), .ready_o  (tx_ready),
      .rd_addr_o(tx_raddr),  .rd_data_i(tx_rdata),
      .tx_en_o  (tx_en_o),   .txd_o    (txd_o)
   );

   eth_rx u_rx (
      .clk_i    (clk_i),    .rst_n_i  (rst_n_i),
      .enable_i (rx_en),    .ack_i    (rx_ack),
      .rx_dv_i  (rx_dv_i),  .rxd_i    (rxd_i),
      .wen_o    (rx_wen),   .waddr_o  (rx_waddr),
      .wdata_o  (rx_wdata), .done_o   (rx_done),
      .crc_err_o(rx_crc_err), .nbytes_o(rx_nbytes)
   );

   // Receiver writes, host reads
   eth_frame_ram u_rx_buf (
      .clk_i  (clk_i),
      .wen_i  (rx_wen),
      .waddr_i(rx_waddr),
      .wdata_i(rx_wdata),
      .raddr_i(rx_raddr),
      .rdata_o(rx_rdata)
   );

endmodule

/* hw/eth_pkg.sv */
package eth_pkg;

   // Buffer and host bus geometry
   localparam int BUFFER_W   = 11;   // 2048 bytes per frame buffer
   localparam int REG_ADDR_W = 13;   // Word address on the host bus

   // Register word addresses
   localparam logic [REG_ADDR_W-1:0] REG_CTRL      = 13'h000;
   localparam logic [REG_ADDR_W-1:0] REG_TX_NBYTES = 13'h001;
   localparam logic [REG_ADDR_W-1:0] REG_STATUS    = 13'h002;
   localparam logic [REG_ADDR_W-1:0] REG_RX_NBYTES = 13'h003;
   localparam logic [REG_ADDR_W-1:0] REG_RX_ACK    = 13'h004;
   localparam logic [REG_ADDR_W-1:0] REG_IRQ_EN    = 13'h005;

   // Buffer windows, bit 12 set and bit 11 picks tx or rx
   localparam logic [REG_ADDR_W-1:0] TX_WIN_BASE = 13'h1000;
   localparam logic [REG_ADDR_W-1:0] RX_WIN_BASE = 13'h1800;

   // CTRL fields
   localparam int SEND_BIT   = 0;    // Strobe only
   localparam int CRC_EN_BIT = 1;
   localparam int RX_EN_BIT  = 2;

   // STATUS fields
   localparam int TX_READY_BIT = 0;
   localparam int RX_DONE_BIT  = 1;
   localparam int CRC_ERR_BIT  = 2;

   // Frame framing
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE      = 8'hD5;
   localparam int         PREAMBLE_LEN  = 7;
   localparam int         FCS_LEN       = 4;

   // CRC-32, reflected form
   localparam logic [31:0] CRC_POLY    = 32'hEDB88320;
   localparam logic [31:0] CRC_INIT    = 32'hFFFFFFFF;
   // Good frame residue, written MSB first
   localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

endpackage

/* hw/eth_regs.sv */
`timescale 1ns/1ps

module eth_regs import eth_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   // Host bus
   input  logic                  req_i,
   input  logic                  we_i,
   input  logic [REG_ADDR_W-1:0] addr_i,
   input  logic [31:0]           wdata_i,
   output logic [31:0]           rdata_o,
   output logic                  rvalid_o,
   // Transmit side
   output logic                  send_o,
   output logic                  crc_en_o,
   output logic [BUFFER_W-1:0]   nbytes_o,
   input  logic                  tx_ready_i,
   output logic                  tx_wen_o,
   output logic [BUFFER_W-1:0]   tx_waddr_o,
   output logic [7:0]            tx_wdata_o,
   // Receive side
   output logic [BUFFER_W-1:0]   rx_raddr_o,
   input  logic [7:0]            rx_rdata_i,
   output logic                  rx_en_o,
   output logic                  rx_ack_o,
   input  logic                  rx_done_i,
   input  logic                  crc_err_i,
   input  logic [BUFFER_W-1:0]   rx_nbytes_i,
   output logic                  irq_o
);

   logic        reg_wr;
   logic        tx_win;
   logic        rx_win;
   logic        irq_en;
   logic        rx_sel_q;   // Read data comes from the rx buffer
   logic [31:0] rd_word;
   logic [31:0] rd_word_q;

   assign tx_win = addr_i[REG_ADDR_W-1 -: 2] == TX_WIN_BASE[REG_ADDR_W-1 -: 2];
   assign rx_win = addr_i[REG_ADDR_W-1 -: 2] == RX_WIN_BASE[REG_ADDR_W-1 -: 2];
   assign reg_wr = req_i && we_i;

   // Strobes act on the same edge as the write
   assign send_o   = reg_wr && (addr_i == REG_CTRL) && wdata_i[SEND_BIT];
   assign rx_ack_o = reg_wr && (addr_i == REG_RX_ACK);

   assign tx_wen_o   = reg_wr && tx_win;
   assign tx_waddr_o = addr_i[BUFFER_W-1:0];
   assign tx_wdata_o = wdata_i[7:0];
   assign rx_raddr_o = addr_i[BUFFER_W-1:0];   // RAM registers it with the request

   always_comb begin
      rd_word = '0;
      case (addr_i)
         REG_CTRL: begin
            rd_word[CRC_EN_BIT] = crc_en_o;
            rd_word[RX_EN_BIT]  = rx_en_o;
         end
         REG_TX_NBYTES: rd_word[BUFFER_W-1:0] = nbytes_o;
         REG_STATUS: begin
            rd_word[TX_READY_BIT] = tx_ready_i;
            rd_word[RX_DONE_BIT]  = rx_done_i;
            rd_word[CRC_ERR_BIT]  = crc_err_i;
         end
         REG_RX_NBYTES: rd_word[BUFFER_W-1:0] = rx_nbytes_i;
         REG_IRQ_EN:    rd_word[0] = irq_en;
         default:       rd_word = '0;   // Tx window reads as zero
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         crc_en_o <= 1'b0;
         rx_en_o  <= 1'b0;
         nbytes_o <= '0;
         irq_en   <= 1'b0;
         rvalid_o <= 1'b0;
         rx_sel_q <= 1'b0;
         irq_o    <= 1'b0;
      end else begin
         rvalid_o <= req_i && !we_i;
         rx_sel_q <= req_i && !we_i && rx_win;
         irq_o    <= rx_done_i && irq_en;
         if (reg_wr) begin
            case (addr_i)
               REG_CTRL: begin
                  crc_en_o <= wdata_i[CRC_EN_BIT];
                  rx_en_o  <= wdata_i[RX_EN_BIT];
               end
               REG_TX_NBYTES: nbytes_o <= wdata_i[BUFFER_W-1:0];
               REG_IRQ_EN:    irq_en <= wdata_i[0];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_i && !we_i) rd_word_q <= rd_word;
   end

   assign rdata_o = rx_sel_q ? {24'h0, rx_rdata_i} : rd_word_q;

endmodule

/* hw/eth_rx.sv */
`timescale 1ns/1ps

module eth_rx import eth_pkg::*; (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                enable_i,
   input  logic                ack_i,
   input  logic                rx_dv_i,
   input  logic [3:0]          rxd_i,
   output logic                wen_o,
   output logic [BUFFER_W-1:0] waddr_o,
   output logic [7:0]          wdata_o,
   output logic                done_o,
   output logic                crc_err_o,
   output logic [BUFFER_W-1:0] nbytes_o
);

   typedef enum logic [1:0] {R_IDLE, R_HUNT, R_DATA, R_DROP} rx_state_t;

   rx_state_t           state;
   logic                phase;
   logic [BUFFER_W-1:0] cnt;        // Bytes stored so far
   logic [3:0]          prev_nib;
   logic [31:0]         crc;
   logic [31:0]         crc_rev;

   eth_crc32 u_crc (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .init_i  (state == R_IDLE),
      .en_i    ((state == R_DATA) && rx_dv_i),
      .nibble_i(rxd_i),
      .crc_o   (crc)
   );

   // Residue constant is in MSB first order
   assign crc_rev = {<<{crc}};

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state     <= R_IDLE;
         phase     <= 1'b0;
         cnt       <= '0;
         wen_o     <= 1'b0;
         done_o    <= 1'b0;
         crc_err_o <= 1'b0;
         nbytes_o  <= '0;
      end else begin
         wen_o <= 1'b0;
         if (ack_i) begin
            done_o    <= 1'b0;
            crc_err_o <= 1'b0;
         end
         case (state)
            R_IDLE: if (rx_dv_i) begin
               // Buffer still owned by the host, skip this frame
               state <= (enable_i && !done_o) ? R_HUNT : R_DROP;
            end
            R_HUNT: begin
               if (!rx_dv_i) begin
                  state <= R_IDLE;   // No SFD seen
               end else if ({rxd_i, prev_nib} == SFD_BYTE) begin
                  state <= R_DATA;
                  phase <= 1'b0;
                  cnt   <= '0;
               end
            end
            R_DATA: begin
               if (!rx_dv_i) begin
                  state     <= R_IDLE;
                  done_o    <= 1'b1;
                  nbytes_o  <= cnt;
                  crc_err_o <= (crc_rev != CRC_RESIDUE);
               end else begin
                  phase <= ~phase;
                  if (phase) begin
                     wen_o <= 1'b1;
                     cnt   <= cnt + 1'b1;
                  end
               end
            end
            R_DROP: if (!rx_dv_i) state <= R_IDLE;
            default: state <= R_IDLE;
         endcase
      end
   end

   // Byte assembly, low nibble arrives first
   always_ff @(posedge clk_i) begin
      prev_nib <= rxd_i;
      if ((state == R_DATA) && rx_dv_i && phase) begin
         wdata_o <= {rxd_i, prev_nib};
         waddr_o <= cnt;
      end
   end

   // Last byte must land before the host is told the frame is complete
   a_no_write_when_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      done_o |-> !wen_o)
      else $error("eth_rx: buffer write while frame pending");

endmodule

/* hw/eth_tx.sv */
`timescale 1ns/1ps

module eth_tx import eth_pkg::*; (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                send_i,
   input  logic                crc_en_i,
   input  logic [BUFFER_W-1:0] nbytes_i,
   output logic                ready_o,
   output logic [BUFFER_W-1:0] rd_addr_o,
   input  logic [7:0]          rd_data_i,
   output logic                tx_en_o,
   output logic [3:0]          txd_o
);

   typedef enum logic [2:0] {S_IDLE, S_PRE, S_SFD, S_DATA, S_FCS} tx_state_t;

   tx_state_t           state;
   logic                phase;      // High nibble when set
   logic [BUFFER_W-1:0] cnt;
   logic [BUFFER_W-1:0] nbytes_q;
   logic                crc_en_q;
   logic [3:0]          nib;
   logic [4:0]          fcs_sel;
   logic [31:0]         crc;

   assign ready_o = (state == S_IDLE) && !tx_en_o;
   assign fcs_sel = {cnt[1:0], phase, 2'b00};

   eth_crc32 u_crc (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .init_i  (send_i && ready_o),
      .en_i    (state == S_DATA),
      .nibble_i(nib),
      .crc_o   (crc)
   );

   // Nibble for the current cycle is registered onto the MII below
   always_comb begin
      case (state)
         S_PRE:   nib = phase ? PREAMBLE_BYTE[7:4] : PREAMBLE_BYTE[3:0];
         S_SFD:   nib = phase ? SFD_BYTE[7:4] : SFD_BYTE[3:0];
         S_DATA:  nib = phase ? rd_data_i[7:4] : rd_data_i[3:0];
         S_FCS:   nib = ~crc[fcs_sel +: 4];   // Inverted CRC goes low byte first
         default: nib = 4'h0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state     <= S_IDLE;
         phase     <= 1'b0;
         cnt       <= '0;
         rd_addr_o <= '0;
         nbytes_q  <= '0;
         crc_en_q  <= 1'b0;
         tx_en_o   <= 1'b0;
         txd_o     <= 4'h0;
      end else begin
         tx_en_o <= (state != S_IDLE);
         txd_o   <= nib;
         phase   <= (state != S_IDLE) ? ~phase : 1'b0;
         case (state)
            S_IDLE: if (send_i && ready_o) begin
               state     <= S_PRE;
               cnt       <= '0;
               rd_addr_o <= '0;   // First byte ready by end of SFD
               nbytes_q  <= nbytes_i;
            end
            S_PRE: begin
               if (!phase && (cnt == '0)) begin
                  crc_en_q <= crc_en_i;   // Picks up CRC_EN written with the send
               end
               if (phase) begin
                  if (cnt == PREAMBLE_LEN - 1) begin
                     state <= S_SFD;
                     cnt   <= '0;
                  end else begin
                     cnt <= cnt + 1'b1;
                  end
               end
            end
            S_SFD: if (phase) begin
               if (nbytes_q != '0) begin
                  state <= S_DATA;
               end else begin
                  state <= crc_en_q ? S_FCS : S_IDLE;
               end
            end
            S_DATA: begin
               if (!phase) begin
                  rd_addr_o <= rd_addr_o + 1'b1;   // Prefetch next byte
               end else if (cnt == nbytes_q - 1'b1) begin
                  cnt   <= '0;
                  state <= crc_en_q ? S_FCS : S_IDLE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            S_FCS: if (phase) begin
               if (cnt == FCS_LEN - 1) begin
                  state <= S_IDLE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Read address moves to the next byte once the low nibble is out
   a_prefetch_in_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state == S_DATA) |-> (rd_addr_o == cnt + BUFFER_W'(phase)))
      else $error("eth_tx: prefetch address out of step");

endmodule

/* project.f */
hw/eth_pkg.sv
hw/eth_crc32.sv
hw/eth_frame_ram.sv
hw/eth_tx.sv
hw/eth_rx.sv
hw/eth_regs.sv
hw/eth_mac.sv
test/tb_eth_mac.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
   --top-module tb_eth_mac -o tb_eth_mac

# Simulator status is ignored, the pass line decides
out=$(./obj_dir/tb_eth_mac) || true
echo "$out"

if echo "$out" | grep -q "Testbench passed"; then
   exit 0
else
   exit 1
fi

/* test/tb_eth_mac.sv */
`timescale 1ns/1ps

module tb_eth_mac import eth_pkg::*; ();

   localparam int          N_ROWS       = 6;
   localparam int          MAX_BYTES    = 68;
   localparam logic [31:0] GOOD_RESIDUE = 32'hDEBB20E3;   // Reflected register after good FCS

   // Frame table, one frame per row; row 4 arrives while row 3 is unacknowledged
   localparam int ROW_LEN     [N_ROWS] = '{46, 60, 33, 20, 50, 8};
   localparam int ROW_CRC_EN  [N_ROWS] = '{1, 1, 0, 1, 1, 1};
   localparam int ROW_CORRUPT [N_ROWS] = '{0, 1, 0, 0, 0, 0};
   localparam int ROW_CRC_ERR [N_ROWS] = '{0, 1, 1, 0, 0, 0};
   localparam int ROW_ACK     [N_ROWS] = '{1, 1, 1, 0, 1, 1};

   logic                  clk;
   logic                  rst_n;
   logic                  req;
   logic                  we;
   logic [REG_ADDR_W-1:0] addr;
   logic [31:0]           wdata;
   logic [31:0]           rdata;
   logic                  rvalid;
   logic                  tx_en;
   logic [3:0]            txd;
   logic                  rx_dv;
   logic [3:0]            rxd;
   logic                  irq;

   int          nib_idx;     // Nibble position inside the tx_en run
   int          flip_idx;    // -1 for a clean frame
   int          en_cycles;
   int          en_runs;
   logic        prev_en;
   logic [7:0]  wire_bytes [MAX_BYTES];   // Payload plus FCS as sent
   logic [7:0]  exp_bytes  [MAX_BYTES];   // What the rx buffer must hold
   int          wire_count;
   int          exp_count;
   int          exp_err;
   logic [31:0] rng_state;

   eth_mac u_eth_mac (
      .clk_i   (clk),    .rst_n_i (rst_n),
      .req_i   (req),    .we_i    (we),
      .addr_i  (addr),   .wdata_i (wdata),
      .rdata_o (rdata),  .rvalid_o(rvalid),
      .tx_en_o (tx_en),  .txd_o   (txd),
      .rx_dv_i (rx_dv),  .rxd_i   (rxd),
      .irq_o   (irq)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // MII loopback, one nibble may be inverted
   always @(posedge clk) begin
      #1;
      if (tx_en) begin
         if (!prev_en) en_runs = en_runs + 1;
         en_cycles = en_cycles + 1;
         rxd       = (nib_idx == flip_idx) ? ~txd : txd;
         nib_idx   = nib_idx + 1;
      end else begin
         rxd     = txd;
         nib_idx = 0;
      end
      rx_dv   = tx_en;
      prev_en = tx_en;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Bitwise reflected CRC-32, LSB first, no final inversion
   function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
      logic [31:0] c;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         if (c[0] ^ b[i]) begin
            c = (c >> 1) ^ 32'hEDB88320;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   function automatic logic [31:0] status_bit(input logic [31:0] st, input int pos);
      return (st >> pos) & 32'd1;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
         $display("Testbench failed");
         $fatal(1, "Check failed on %s", name);
      end
   endtask

   // Bus tasks start and end 1 ns after a rising edge
   task automatic bus_write(input logic [REG_ADDR_W-1:0] a, input logic [31:0] d);
      req   = 1'b1;
      we    = 1'b1;
      addr  = a;
      wdata = d;
      @(posedge clk);
      #1;
      req = 1'b0;
      we  = 1'b0;
   endtask

   task automatic bus_read(input logic [REG_ADDR_W-1:0] a, output logic [31:0] d);
      req  = 1'b1;
      we   = 1'b0;
      addr = a;
      @(posedge clk);
      #1;
      req = 1'b0;
      check_value("rvalid_o", {31'b0, rvalid}, 1);
      d = rdata;
   endtask

   task automatic wait_status(input int pos, input int val);
      logic [31:0] st;
      bus_read(REG_STATUS, st);
      while (status_bit(st, pos) != val) bus_read(REG_STATUS, st);
   endtask

   // Random payload, FCS appended low byte first when enabled
   task automatic build_frame(input int len, input int crc_en);
      logic [31:0] crc;
      logic [31:0] fcs;
      crc = 32'hFFFFFFFF;
      for (int i = 0; i < len; i++) begin
         rng_state     = xorshift(rng_state);
         wire_bytes[i] = rng_state[7:0];
         crc           = crc_byte(crc, wire_bytes[i]);
      end
      fcs        = ~crc;
      wire_count = len;
      if (crc_en != 0) begin
         for (int k = 0; k < 4; k++) wire_bytes[len+k] = fcs[8*k +: 8];
         wire_count = len + 4;
      end
   endtask

   // Watchdog sized from the frame table
   initial begin
      int limit;
      limit = 300;   // Reset and register tests
      for (int r = 0; r < N_ROWS; r++) limit += 2 * (ROW_LEN[r] + 12) + 200;
      repeat (limit) @(posedge clk);
      $display("Timeout: frames not finished after %0d cycles", limit);
      $display("Testbench failed");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      logic [31:0] st;
      logic [31:0] v;
      logic [31:0] crc;
      int          len;
      int          drop;
      rst_n = 1'b0;
      req   = 1'b0;
      we    = 1'b0;
      addr  = '0;
      wdata = '0;
      rx_dv = 1'b0;
      rxd   = 4'h0;
      prev_en   = 1'b0;
      nib_idx   = 0;
      flip_idx  = -1;
      en_cycles = 0;
      en_runs   = 0;
      exp_count = 0;
      exp_err   = 0;
      rng_state = 32'd60763;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;

      bus_read(REG_STATUS, st);
      check_value("STATUS.TX_READY", status_bit(st, TX_READY_BIT), 1);
      check_value("STATUS.RX_DONE", status_bit(st, RX_DONE_BIT), 0);
      check_value("STATUS.CRC_ERR", status_bit(st, CRC_ERR_BIT), 0);
      check_value("irq_o", {31'b0, irq}, 0);
      bus_read(REG_IRQ_EN, v);
      check_value("IRQ_EN", v, 0);

      // Readback masked to field width
      bus_write(REG_TX_NBYTES, 32'hFFFF_F9AB);
      bus_read(REG_TX_NBYTES, v);
      check_value("TX_NBYTES", v, 32'hFFFF_F9AB & 32'h7FF);
      bus_write(REG_IRQ_EN, 32'hFFFF_FFFE);
      bus_read(REG_IRQ_EN, v);
      check_value("IRQ_EN", v, 0);
      bus_write(REG_IRQ_EN, 32'h3);
      bus_read(REG_IRQ_EN, v);
      check_value("IRQ_EN", v, 1);

      for (int row = 0; row < N_ROWS; row++) begin
         len  = ROW_LEN[row];
         drop = (row > 0 && ROW_ACK[row-1] == 0) ? 1 : 0;
         build_frame(len, ROW_CRC_EN[row]);
         for (int i = 0; i < len; i++) begin
            bus_write(TX_WIN_BASE | REG_ADDR_W'(i), {24'h0, wire_bytes[i]});
         end
         if (drop == 0) begin
            exp_count = wire_count;
            for (int i = 0; i < wire_count; i++) exp_bytes[i] = wire_bytes[i];
            if (ROW_CORRUPT[row] != 0) exp_bytes[len/2] = exp_bytes[len/2] ^ 8'h0F;
            crc = 32'hFFFFFFFF;
            for (int i = 0; i < exp_count; i++) crc = crc_byte(crc, exp_bytes[i]);
            exp_err = (crc != GOOD_RESIDUE) ? 1 : 0;
            check_value("table CRC_ERR vs residue", exp_err, ROW_CRC_ERR[row]);
         end
         flip_idx  = (ROW_CORRUPT[row] != 0) ? 2 * (8 + len / 2) : -1;   // Low nibble
         en_cycles = 0;
         en_runs   = 0;
         bus_write(REG_TX_NBYTES, len);
         bus_write(REG_CTRL, (1 << SEND_BIT) | (ROW_CRC_EN[row] << CRC_EN_BIT) |
                             (1 << RX_EN_BIT));
         wait_status(TX_READY_BIT, 1);
         check_value("tx_en_o runs", en_runs, 1);
         check_value("tx_en_o cycles", en_cycles, 2 * (8 + len + 4 * ROW_CRC_EN[row]));
         if (drop == 0) wait_status(RX_DONE_BIT, 1);

         // A dropped frame leaves the held one in place
         bus_read(REG_STATUS, st);
         check_value("STATUS.TX_READY", status_bit(st, TX_READY_BIT), 1);
         check_value("STATUS.RX_DONE", status_bit(st, RX_DONE_BIT), 1);
         check_value("STATUS.CRC_ERR", status_bit(st, CRC_ERR_BIT), exp_err);
         check_value("irq_o", {31'b0, irq}, 1);
         bus_read(REG_RX_NBYTES, v);
         check_value("RX_NBYTES", v, exp_count);
         for (int i = 0; i < exp_count; i++) begin
            bus_read(RX_WIN_BASE | REG_ADDR_W'(i), v);
            check_value($sformatf("rx buffer byte %0d", i), v, {24'h0, exp_bytes[i]});
         end

         if (ROW_ACK[row] != 0) begin
            bus_write(REG_RX_ACK, 32'h0);
            bus_read(REG_STATUS, st);
            check_value("STATUS.RX_DONE", status_bit(st, RX_DONE_BIT), 0);
            check_value("STATUS.CRC_ERR", status_bit(st, CRC_ERR_BIT), 0);
            check_value("irq_o", {31'b0, irq}, 0);
         end
      end

      $display("Testbench passed");
      $finish;
   end

endmodule
